//--- src/riscv_pkg.sv
`default_nettype none

package riscv_pkg;

    // ------------------------------------------------------------------
    // Widths
    // ------------------------------------------------------------------
    localparam int xlen           = 32;
    localparam int reg_addr_width = 5;

    typedef logic [xlen-1:0]           word_t;
    typedef logic [reg_addr_width-1:0] reg_idx_t;

    localparam word_t nop_instr = 32'h0000_0013; // addi x0, x0, 0

    // ------------------------------------------------------------------
    // Encodings
    // ------------------------------------------------------------------
    typedef enum logic [6:0] {
        op_reg    = 7'b0110011,
        op_imm    = 7'b0010011,
        op_branch = 7'b1100011
    } opcode_e;

    typedef enum logic [3:0] {
        alu_add  = 4'd0, // Zero so a cleared ID/EX is a plain add
        alu_sub  = 4'd1,
        alu_sll  = 4'd2,
        alu_slt  = 4'd3,
        alu_sltu = 4'd4,
        alu_xor  = 4'd5,
        alu_srl  = 4'd6,
        alu_sra  = 4'd7,
        alu_or   = 4'd8,
        alu_and  = 4'd9
    } alu_op_e;

    // ------------------------------------------------------------------
    // Ports and pipeline registers
    // ------------------------------------------------------------------
    typedef struct packed {
        logic  valid;
        word_t addr;
    } fetch_req_t;

    typedef struct packed {
        logic  ready;
        word_t instr;
    } fetch_rsp_t;

    typedef struct packed {
        word_t pc;
        word_t instr;
    } if_id_t;

    typedef struct packed {
        logic     valid;     // Low for a bubble
        word_t    pc;
        reg_idx_t rs1;
        reg_idx_t rs2;
        reg_idx_t rd;
        word_t    rs1_data;
        word_t    rs2_data;
        word_t    imm;
        alu_op_e  alu_op;
        logic     use_imm;
        logic     reg_write;
        logic     is_beq;
    } id_ex_t;

    typedef struct packed {
        logic     reg_write;
        reg_idx_t rd;
        word_t    result;
    } ex_wb_t;

    typedef struct packed {
        logic     valid;
        reg_idx_t rd;
        word_t    data;
    } retire_t;

    typedef struct packed {
        logic  taken;
        word_t target;
    } redirect_t;

endpackage

`default_nettype wire

//--- src/alu.sv
`timescale 1ns/1ps
`default_nettype none

module alu (
    input  riscv_pkg::alu_op_e alu_op,
    input  riscv_pkg::word_t   a,
    input  riscv_pkg::word_t   b,
    output riscv_pkg::word_t   result
);
    import riscv_pkg::*;

    logic [4:0] shamt;

    assign shamt = b[4:0];

    always_comb begin
        case (alu_op)
            alu_add:  result = a + b;
            alu_sub:  result = a - b;
            alu_sll:  result = a << shamt;
            alu_slt:  result = {{(xlen-1){1'b0}}, $signed(a) < $signed(b)};
            alu_sltu: result = {{(xlen-1){1'b0}}, a < b};
            alu_xor:  result = a ^ b;
            alu_srl:  result = a >> shamt;
            alu_sra:  result = word_t'($signed(a) >>> shamt);
            alu_or:   result = a | b;
            alu_and:  result = a & b;
            default:  result = '0;
        endcase
    end

    // ID/EX is cleared by reset, so a bad code means broken decode
    always_comb begin
        assert final (alu_op inside {alu_add, alu_sub, alu_sll, alu_slt, alu_sltu,
                                     alu_xor, alu_srl, alu_sra, alu_or, alu_and})
            else $error("alu_op is unknown or out of range");
    end

endmodule

`default_nettype wire

//--- src/fetch_stage.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_stage (
    input  logic                   clk,
    input  logic                   reset_n,
    output riscv_pkg::fetch_req_t  fetch_req,
    input  riscv_pkg::fetch_rsp_t  fetch_rsp,
    input  riscv_pkg::redirect_t   redirect,
    output riscv_pkg::if_id_t      if_id
);
    import riscv_pkg::*;

    word_t pc;
    logic  req_valid; // Rises on the first edge out of reset
    logic  accept;

    assign fetch_req.valid = req_valid;
    assign fetch_req.addr  = pc;

    assign accept = fetch_req.valid && fetch_rsp.ready;

    // ------------------------------------------------------------------
    // PC and IF/ID register
    // ------------------------------------------------------------------
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            req_valid   <= 1'b0;
            pc          <= '0;
            if_id.pc    <= '0;
            if_id.instr <= nop_instr;
        end else begin
            req_valid <= 1'b1;
            if_id.pc  <= pc;
            if (redirect.taken) begin
                // Any fetch landing now belongs to the wrong path
                pc          <= redirect.target;
                if_id.instr <= nop_instr;
            end else if (accept) begin
                pc          <= pc + 32'd4;
                if_id.instr <= fetch_rsp.instr;
            end else begin
                if_id.instr <= nop_instr; // Stall bubble, PC holds
            end
        end
    end

    // Request address may only move on acceptance or a branch redirect
    assert property (@(posedge clk) disable iff (!reset_n)
        fetch_req.valid && !fetch_rsp.ready && !redirect.taken
            |=> $stable(fetch_req.addr))
        else $error("fetch address changed while waiting for ready");

endmodule

`default_nettype wire

//--- src/register_file.sv
`timescale 1ns/1ps
`default_nettype none

module register_file (
    input  logic                clk,
    input  logic                reset_n,
    input  riscv_pkg::reg_idx_t rs1,
    input  riscv_pkg::reg_idx_t rs2,
    output riscv_pkg::word_t    rs1_data,
    output riscv_pkg::word_t    rs2_data,
    input  riscv_pkg::ex_wb_t   ex_wb
);
    import riscv_pkg::*;

    word_t regs [1:31]; // x0 has no storage
    logic  wr_en;

    assign wr_en = reset_n && ex_wb.reg_write && (ex_wb.rd != '0);

    always_ff @(posedge clk) begin
        if (wr_en) begin
            regs[ex_wb.rd] <= ex_wb.result;
        end
    end

    // Write-through so ID sees the value being written this cycle
    function automatic word_t read_port(input reg_idx_t idx);
        word_t data;
        if (idx == '0) begin
            data = '0;
        end else if (wr_en && (ex_wb.rd == idx)) begin
            data = ex_wb.result;
        end else begin
            data = regs[idx];
        end
        return data;
    endfunction

    assign rs1_data = read_port(rs1);
    assign rs2_data = read_port(rs2);

endmodule

`default_nettype wire

//--- src/decode_stage.sv
`timescale 1ns/1ps
`default_nettype none

module decode_stage (
    input  logic                 clk,
    input  logic                 reset_n,
    input  riscv_pkg::if_id_t    if_id,
    input  riscv_pkg::redirect_t redirect,
    input  riscv_pkg::word_t     rs1_data,
    input  riscv_pkg::word_t     rs2_data,
    output riscv_pkg::reg_idx_t  rs1,
    output riscv_pkg::reg_idx_t  rs2,
    output riscv_pkg::id_ex_t    id_ex
);
    import riscv_pkg::*;

    // ------------------------------------------------------------------
    // Fields and immediates
    // ------------------------------------------------------------------
    word_t      instr;
    opcode_e    opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    word_t      imm_i;
    word_t      imm_shamt;
    word_t      imm_b;
    id_ex_t     id_ex_next;

    assign instr  = if_id.instr;
    assign opcode = opcode_e'(instr[6:0]);
    assign funct3 = instr[14:12];
    assign funct7 = instr[31:25];
    assign rs1    = instr[19:15];
    assign rs2    = instr[24:20];

    assign imm_i     = {{20{instr[31]}}, instr[31:20]};
    assign imm_shamt = {27'b0, instr[24:20]};
    assign imm_b     = {{19{instr[31]}}, instr[31], instr[7], instr[30:25],
                        instr[11:8], 1'b0};

    // ------------------------------------------------------------------
    // Control decode
    // ------------------------------------------------------------------
    always_comb begin
        id_ex_next           = '0; // Bubble unless recognised below
        id_ex_next.pc        = if_id.pc;
        id_ex_next.rs1       = rs1;
        id_ex_next.rs2       = rs2;
        id_ex_next.rd        = instr[11:7];
        id_ex_next.rs1_data  = rs1_data;
        id_ex_next.rs2_data  = rs2_data;
        id_ex_next.imm       = imm_i;
        id_ex_next.alu_op    = alu_add;

        case (opcode)
            op_reg: begin
                id_ex_next.valid     = 1'b1;
                id_ex_next.reg_write = 1'b1;
                case (funct3)
                    3'b000:  id_ex_next.alu_op = funct7[5] ? alu_sub : alu_add;
                    3'b001:  id_ex_next.alu_op = alu_sll;
                    3'b010:  id_ex_next.alu_op = alu_slt;
                    3'b011:  id_ex_next.alu_op = alu_sltu;
                    3'b100:  id_ex_next.alu_op = alu_xor;
                    3'b101:  id_ex_next.alu_op = funct7[5] ? alu_sra : alu_srl;
                    3'b110:  id_ex_next.alu_op = alu_or;
                    default: id_ex_next.alu_op = alu_and;
                endcase
            end
            op_imm: begin
                id_ex_next.valid     = 1'b1;
                id_ex_next.reg_write = 1'b1;
                id_ex_next.use_imm   = 1'b1;
                case (funct3)
                    3'b000:  id_ex_next.alu_op = alu_add;
                    3'b010:  id_ex_next.alu_op = alu_slt;
                    3'b011:  id_ex_next.alu_op = alu_sltu;
                    3'b100:  id_ex_next.alu_op = alu_xor;
                    3'b110:  id_ex_next.alu_op = alu_or;
                    3'b111:  id_ex_next.alu_op = alu_and;
                    3'b001: begin
                        id_ex_next.alu_op = alu_sll;
                        id_ex_next.imm    = imm_shamt;
                    end
                    default: begin // srli / srai
                        id_ex_next.alu_op = funct7[5] ? alu_sra : alu_srl;
                        id_ex_next.imm    = imm_shamt;
                    end
                endcase
            end
            op_branch: begin
                if (funct3 == 3'b000) begin // Only BEQ
                    id_ex_next.valid  = 1'b1;
                    id_ex_next.is_beq = 1'b1;
                    id_ex_next.imm    = imm_b;
                    id_ex_next.alu_op = alu_sub;
                end
            end
            default: ;
        endcase
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            id_ex <= '0;
        end else if (redirect.taken) begin
            id_ex <= '0; // Wrong-path instruction
        end else begin
            id_ex <= id_ex_next;
        end
    end

endmodule

`default_nettype wire

//--- src/execute_stage.sv
`timescale 1ns/1ps
`default_nettype none

module execute_stage (
    input  logic                 clk,
    input  logic                 reset_n,
    input  riscv_pkg::id_ex_t    id_ex,
    output riscv_pkg::ex_wb_t    ex_wb,
    output riscv_pkg::redirect_t redirect,
    output riscv_pkg::retire_t   retire
);
    import riscv_pkg::*;

    logic  fwd_rs1;
    logic  fwd_rs2;
    word_t op_a;
    word_t rs2_val;  // rs2 after forwarding, before the immediate mux
    word_t op_b;
    word_t alu_result;
    logic  live;     // Valid and not on the wrong path
    logic  beq_taken;

    // ------------------------------------------------------------------
    // Forwarding from EX/WB
    // ------------------------------------------------------------------
    assign fwd_rs1 = ex_wb.reg_write && (ex_wb.rd != '0) && (ex_wb.rd == id_ex.rs1);
    assign fwd_rs2 = ex_wb.reg_write && (ex_wb.rd != '0) && (ex_wb.rd == id_ex.rs2);

    assign op_a    = fwd_rs1 ? ex_wb.result : id_ex.rs1_data;
    assign rs2_val = fwd_rs2 ? ex_wb.result : id_ex.rs2_data;
    assign op_b    = id_ex.use_imm ? id_ex.imm : rs2_val;

    alu alu_inst (
        .alu_op (id_ex.alu_op),
        .a      (op_a),
        .b      (op_b),
        .result (alu_result)
    );

    // ------------------------------------------------------------------
    // Branch resolution and EX/WB register
    // ------------------------------------------------------------------
    assign live      = id_ex.valid && !redirect.taken;
    assign beq_taken = live && id_ex.is_beq && (op_a == rs2_val);

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            ex_wb    <= '0;
            redirect <= '0;
        end else begin
            ex_wb.reg_write <= live && id_ex.reg_write;
            ex_wb.rd        <= id_ex.rd;
            ex_wb.result    <= alu_result;
            redirect.taken  <= beq_taken;
            redirect.target <= id_ex.pc + id_ex.imm;
        end
    end

    assign retire.valid = ex_wb.reg_write && (ex_wb.rd != '0);
    assign retire.rd    = ex_wb.rd;
    assign retire.data  = ex_wb.result;

    // The two slots behind a taken BEQ are flushed and never retire
    assert property (@(posedge clk) disable iff (!reset_n)
        redirect.taken |=> !retire.valid ##1 !retire.valid)
        else $error("wrong-path instruction retired after a taken branch");

endmodule

`default_nettype wire

//--- src/riscv_core.sv
`timescale 1ns/1ps
`default_nettype none

module riscv_core (
    input  logic                  clk,
    input  logic                  reset_n,
    output riscv_pkg::fetch_req_t fetch_req,
    input  riscv_pkg::fetch_rsp_t fetch_rsp,
    output riscv_pkg::retire_t    retire
);
    import riscv_pkg::*;

    if_id_t    if_id;
    id_ex_t    id_ex;
    ex_wb_t    ex_wb;
    redirect_t redirect;
    reg_idx_t  rs1;
    reg_idx_t  rs2;
    word_t     rs1_data;
    word_t     rs2_data;

    // ------------------------------------------------------------------
    // IF, ID, EX and the register file as WB
    // ------------------------------------------------------------------
    fetch_stage fetch_stage_inst (
        .clk       (clk),
        .reset_n   (reset_n),
        .fetch_req (fetch_req),
        .fetch_rsp (fetch_rsp),
        .redirect  (redirect),
        .if_id     (if_id)
    );

    register_file register_file_inst (
        .clk      (clk),
        .reset_n  (reset_n),
        .rs1      (rs1),
        .rs2      (rs2),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .ex_wb    (ex_wb)       // Write port
    );

    decode_stage decode_stage_inst (
        .clk      (clk),
        .reset_n  (reset_n),
        .if_id    (if_id),
        .redirect (redirect),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .rs1      (rs1),
        .rs2      (rs2),
        .id_ex    (id_ex)
    );

    execute_stage execute_stage_inst (
        .clk      (clk),
        .reset_n  (reset_n),
        .id_ex    (id_ex),
        .ex_wb    (ex_wb),
        .redirect (redirect),
        .retire   (retire)
    );

endmodule

`default_nettype wire

//--- include/tb_program.svh
`ifndef tb_program_svh
`define tb_program_svh

// Columns: instruction word, retires, expected rd, expected data
typedef struct packed {
    word_t    instr;
    logic     retires;
    reg_idx_t rd;
    word_t    data;
} prog_row_t;

localparam int    prog_len     = 31;
localparam word_t taken_target = 32'h0000_006C; // Landing address of the taken BEQ
localparam int    cycle_limit  = 10 * prog_len + 200;

localparam prog_row_t program_table [prog_len] = '{
    '{32'h00500093, 1'b1, 5'd1,  32'h00000005}, // addi x1, x0, 5
    '{32'hFFD00113, 1'b1, 5'd2,  32'hFFFFFFFD}, // addi x2, x0, -3
    '{32'h002081B3, 1'b1, 5'd3,  32'h00000002}, // add  x3, x1, x2
    '{32'h40118233, 1'b1, 5'd4,  32'hFFFFFFFD}, // sub  x4, x3, x1
    '{32'h003092B3, 1'b1, 5'd5,  32'h00000014}, // sll  x5, x1, x3
    '{32'h00112333, 1'b1, 5'd6,  32'h00000001}, // slt  x6, x2, x1
    '{32'h001133B3, 1'b1, 5'd7,  32'h00000000}, // sltu x7, x2, x1
    '{32'h00524433, 1'b1, 5'd8,  32'hFFFFFFE9}, // xor  x8, x4, x5
    '{32'h003254B3, 1'b1, 5'd9,  32'h3FFFFFFF}, // srl  x9, x4, x3
    '{32'h40325533, 1'b1, 5'd10, 32'hFFFFFFFF}, // sra  x10, x4, x3
    '{32'h0020E5B3, 1'b1, 5'd11, 32'hFFFFFFFD}, // or   x11, x1, x2
    '{32'h0020F633, 1'b1, 5'd12, 32'h00000005}, // and  x12, x1, x2
    '{32'h00C606B3, 1'b1, 5'd13, 32'h0000000A}, // add  x13, x12, x12
    '{32'h00D686B3, 1'b1, 5'd13, 32'h00000014}, // add  x13, x13, x13
    '{32'hFE768713, 1'b1, 5'd14, 32'hFFFFFFFB}, // addi x14, x13, -25
    '{32'hFFC72793, 1'b1, 5'd15, 32'h00000001}, // slti x15, x14, -4
    '{32'hFFF73813, 1'b1, 5'd16, 32'h00000001}, // sltiu x16, x14, -1
    '{32'hFFF74893, 1'b1, 5'd17, 32'h00000004}, // xori x17, x14, -1
    '{32'hFF00E913, 1'b1, 5'd18, 32'hFFFFFFF5}, // ori  x18, x1, -16
    '{32'hFFE77993, 1'b1, 5'd19, 32'hFFFFFFFA}, // andi x19, x14, -2
    '{32'h00471A13, 1'b1, 5'd20, 32'hFFFFFFB0}, // slli x20, x14, 4
    '{32'h01C75A93, 1'b1, 5'd21, 32'h0000000F}, // srli x21, x14, 28
    '{32'h40175B13, 1'b1, 5'd22, 32'hFFFFFFFD}, // srai x22, x14, 1
    '{32'h00708013, 1'b0, 5'd0,  32'h00000000}, // addi x0, x1, 7
    '{32'h00C08663, 1'b0, 5'd0,  32'h00000000}, // beq  x1, x12, +12 (taken)
    '{32'h00100B93, 1'b0, 5'd0,  32'h00000000}, // addi x23, x0, 1 (skipped)
    '{32'h00200C13, 1'b0, 5'd0,  32'h00000000}, // addi x24, x0, 2 (skipped)
    '{32'h00960C93, 1'b1, 5'd25, 32'h0000000E}, // addi x25, x12, 9
    '{32'h00208463, 1'b0, 5'd0,  32'h00000000}, // beq  x1, x2, +8 (not taken)
    '{32'h001C8D13, 1'b1, 5'd26, 32'h0000000F}, // addi x26, x25, 1
    '{32'h019D0DB3, 1'b1, 5'd27, 32'h0000001D}  // add  x27, x26, x25
};

`endif

//--- tests/tb_riscv_core.sv
`timescale 1ns/1ps
`default_nettype none

module tb_riscv_core;
    import riscv_pkg::*;

    `include "tb_program.svh"

    logic       clk;
    logic       reset_n;
    fetch_req_t fetch_req;
    fetch_rsp_t fetch_rsp;
    retire_t    retire;

    logic  backpressure;   // Random ready when set
    logic  prev_waiting;
    word_t prev_addr;
    int    expected_rows [$];
    int    ret_count;      // Retires seen since the last reset
    int    error_count;
    int    test_count;
    int    failed_tests;
    int    cycle_count;

    riscv_core riscv_core_inst (
        .clk       (clk),
        .reset_n   (reset_n),
        .fetch_req (fetch_req),
        .fetch_rsp (fetch_rsp),
        .retire    (retire)
    );

    always #2 clk = ~clk;

    // ------------------------------------------------------------------
    // Helpers
    // ------------------------------------------------------------------
    task automatic compare_value(input string name, input word_t actual, input word_t expected);
        if (actual !== expected) begin
            $display("mismatch at %0t: %s is %h, expected %h", $time, name, actual, expected);
            error_count++;
        end
    endtask

    function automatic word_t read_instr(input word_t addr);
        word_t index;
        word_t word;
        index = addr >> 2;
        word  = nop_instr;  // Past the end of the program
        if (index < prog_len) begin
            word = program_table[index].instr;
        end
        return word;
    endfunction

    task automatic apply_reset();
        @(negedge clk);
        reset_n = 1'b0;
        repeat (4) begin
            @(negedge clk);
            compare_value("retire.valid", 32'(retire.valid), 32'd0);
            compare_value("fetch_req.valid", 32'(fetch_req.valid), 32'd0);
            compare_value("fetch_req.addr", fetch_req.addr, 32'd0);
        end
        reset_n = 1'b1;
        @(negedge clk);
        compare_value("retire.valid", 32'(retire.valid), 32'd0); // First cycle out of reset
        compare_value("fetch_req.addr", fetch_req.addr, 32'd0);
        compare_value("fetch_req.valid", 32'(fetch_req.valid), 32'd1);
    endtask

    task automatic report_test(input string name, input int errors_before);
        test_count++;
        if (error_count == errors_before) begin
            $display("test %s: ok", name);
        end else begin
            failed_tests++;
            $display("test %s: %0d errors", name, error_count - errors_before);
        end
    endtask

    task automatic run_program(input string name, input logic random_ready);
        int errors_before;
        errors_before = error_count;
        backpressure  = random_ready;
        apply_reset();
        while (ret_count < expected_rows.size()) begin
            @(posedge clk);
        end
        repeat (20) @(posedge clk); // Anything retiring now is extra
        report_test(name, errors_before);
    endtask

    // ------------------------------------------------------------------
    // Memory model and retire monitor
    // ------------------------------------------------------------------
    always @(negedge clk) begin
        int row;
        if (!reset_n) begin
            ret_count = 0;
        end else begin
            if (prev_waiting && fetch_req.addr != prev_addr && fetch_req.addr != taken_target) begin
                $display("fetch address moved from %h to %h at %0t while waiting for ready",
                         prev_addr, fetch_req.addr, $time);
                error_count++;
            end
            if (retire.valid) begin
                if (ret_count < expected_rows.size()) begin
                    row = expected_rows[ret_count];
                    compare_value("retire.rd", 32'(retire.rd), 32'(program_table[row].rd));
                    compare_value("retire.data", retire.data, program_table[row].data);
                end else begin
                    $display("unexpected retire of x%0d at %0t beyond the end of the program",
                             retire.rd, $time);
                    error_count++;
                end
                ret_count++;
            end
        end
        fetch_rsp.ready = backpressure ? (($urandom % 2) != 0) : 1'b1;
        fetch_rsp.instr = read_instr(fetch_req.addr);
        prev_waiting    = reset_n && fetch_req.valid && !fetch_rsp.ready;
        prev_addr       = fetch_req.addr;
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= cycle_limit) begin
            $display("timeout after %0d cycles with %0d of %0d retires seen",
                     cycle_count, ret_count, expected_rows.size());
            $display("sim failed");
            $finish;
        end
    end

    // ------------------------------------------------------------------
    // Test sequence
    // ------------------------------------------------------------------
    initial begin
        int errors_before;
        clk          = 1'b0;
        reset_n      = 1'b0;
        fetch_rsp    = '0;
        backpressure = 1'b0;
        prev_waiting = 1'b0;
        prev_addr    = '0;
        ret_count    = 0;
        error_count  = 0;
        test_count   = 0;
        failed_tests = 0;
        cycle_count  = 0;
        void'($urandom(40391));
        for (int i = 0; i < prog_len; i++) begin
            if (program_table[i].retires) begin
                expected_rows.push_back(i);
            end
        end

        errors_before = error_count;
        apply_reset();
        report_test("reset", errors_before);
        run_program("program with ready held high", 1'b0);
        run_program("program with random back-pressure", 1'b1);

        $display("tests run: %0d, tests with errors: %0d, total errors: %0d",
                 test_count, failed_tests, error_count);
        if (error_count == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- sim.f
+incdir+include
src/riscv_pkg.sv
src/alu.sv
src/fetch_stage.sv
src/register_file.sv
src/decode_stage.sv
src/execute_stage.sv
src/riscv_core.sv
tests/tb_riscv_core.sv

//--- Makefile
TOP       ?= tb_riscv_core
FILELIST  ?= sim.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build $(TOP) with Verilator, run it and check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "Variables: TOP FILELIST BUILD_DIR LOG VERILATOR VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@grep -q "^sim passed$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
